// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f l2_sys.f \
		--top-module tb_l2_sys -o Vtb_l2_sys

run: compile
	./obj_dir/Vtb_l2_sys > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: l2_sys.f
rtl/l2_pkg.sv
rtl/l2_req_arbiter.sv
rtl/l2_tag_table.sv
rtl/l2_pending_buffer.sv
rtl/l2_line_store.sv
rtl/l2_ans_router.sv
rtl/l2_sys.sv
test/l2_sys_chk.sv
test/tb_l2_sys.sv

// File: rtl/l2_ans_router.sv
`timescale 1ns/1ps

module l2_ans_router import l2_pkg::*; (
  input  l2_ans_t ans_i,
  output logic    ans_rdy_o,
  output l2_ans_t icache_ans_o,
  output l2_ans_t dcache_ans_o,
  output l2_ans_t ptw_ans_o,
  input  logic    icache_rdy_i,
  input  logic    dcache_rdy_i,
  input  logic    ptw_rdy_i
);

  // One-hot client select: walker, D-cache, I-cache
  logic [2:0] sel;

  always_comb begin
    case (ans_i.ans_type)
      ILineRead:    sel = 3'b001;
      DLineRead,
      DLineWritten,
      DWbbWakeUp:   sel = 3'b010;
      PTWLoadAns:   sel = 3'b100;
      default:      sel = 3'b000;
    endcase
  end

  // Same payload to all, valid only where it belongs
  always_comb begin
    icache_ans_o       = ans_i;
    dcache_ans_o       = ans_i;
    ptw_ans_o          = ans_i;
    icache_ans_o.valid = ans_i.valid && sel[0];
    dcache_ans_o.valid = ans_i.valid && sel[1];
    ptw_ans_o.valid    = ans_i.valid && sel[2];
  end

  assign ans_rdy_o = (sel[0] && icache_rdy_i) ||
                     (sel[1] && dcache_rdy_i) ||
                     (sel[2] && ptw_rdy_i);

endmodule

// File: rtl/l2_line_store.sv
`timescale 1ns/1ps

module l2_line_store import l2_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  l2_paddr_t            rd_paddr_i,
  output logic [LINE_BITS-1:0] rd_line_o,
  output logic [XLEN-1:0]      rd_data_o,
  input  logic                 wr_en_i,
  input  l2_paddr_t            wr_paddr_i,
  input  logic [LINE_BITS-1:0] wr_line_i
);

  localparam int unsigned ADDR_W     = LS_TAG_BITS + IDX_BITS;
  localparam int unsigned DEPTH      = 2 ** ADDR_W;
  // Byte bits below a line address
  localparam int unsigned LINE_SHIFT = OFF_BITS + BYTE_BITS;

  logic [LINE_BITS-1:0] mem_q [DEPTH];
  logic [ADDR_W-1:0]    rd_addr;
  logic [ADDR_W-1:0]    wr_addr;

  // Upper tag bits alias onto the same line
  assign rd_addr = {rd_paddr_i.tag[LS_TAG_BITS-1:0], rd_paddr_i.idx};
  assign wr_addr = {wr_paddr_i.tag[LS_TAG_BITS-1:0], wr_paddr_i.idx};

  assign rd_line_o = mem_q[rd_addr];
  assign rd_data_o = rd_line_o[rd_paddr_i.line_off*XLEN +: XLEN];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Doubleword k of a line holds the line address plus k
      for (int l = 0; l < DEPTH; l++) begin
        for (int k = 0; k < DW_PER_LINE; k++) begin
          mem_q[l][k*XLEN +: XLEN] <= (XLEN'(l) << LINE_SHIFT) + XLEN'(k);
        end
      end
    end else if (wr_en_i) begin
      mem_q[wr_addr] <= wr_line_i;
    end
  end

endmodule

// File: rtl/l2_pending_buffer.sv
`timescale 1ns/1ps

module l2_pending_buffer import l2_pkg::*; #(
  parameter int unsigned BUF_LEN    = 3,
  parameter int unsigned HIT_DELAY  = 2,
  parameter int unsigned MISS_DELAY = 7
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  l2_req_t              req_i,
  output logic                 req_rdy_o,
  output logic                 lookup_en_o,
  output l2_paddr_t            lookup_paddr_o,
  input  logic                 hit_i,
  output l2_paddr_t            rd_paddr_o,
  input  logic [LINE_BITS-1:0] rd_line_i,
  input  logic [XLEN-1:0]      rd_data_i,
  output logic                 wr_en_o,
  output l2_paddr_t            wr_paddr_o,
  output logic [LINE_BITS-1:0] wr_line_o,
  output l2_ans_t              ans_o,
  input  logic                 ans_rdy_i
);

  localparam int unsigned IDX_W     = (BUF_LEN > 1) ? $clog2(BUF_LEN) : 1;
  localparam int unsigned MAX_DELAY = (HIT_DELAY > MISS_DELAY) ? HIT_DELAY : MISS_DELAY;
  localparam int unsigned CNT_W     = (MAX_DELAY > 0) ? $clog2(MAX_DELAY + 1) : 1;

  l2_req_t            req_q [BUF_LEN];
  logic [CNT_W-1:0]   cnt_q [BUF_LEN];
  logic [BUF_LEN-1:0] valid_q;
  logic [BUF_LEN-1:0] miss_q;
  logic               init_done_q;
  l2_ans_t            ans_q;
  l2_ans_t            ans_d;
  l2_req_t            sel_req;
  logic [IDX_W-1:0]   sel_idx;
  logic [IDX_W-1:0]   ins_idx;
  logic               sel_valid;
  logic               ins_valid;
  logic               ans_block;
  logic               capture;
  logic               accept;

  // Answer register full and not taken
  assign ans_block = ans_q.valid && !ans_rdy_i;
  // No capture while flushing, the entry is dropped instead
  assign capture   = sel_valid && !ans_block && !flush_i;

  // Lowest expired entry answers first
  always_comb begin
    sel_idx   = '0;
    sel_valid = 1'b0;
    for (int k = BUF_LEN - 1; k >= 0; k--) begin
      if (valid_q[k] && (cnt_q[k] == '0)) begin
        sel_idx   = IDX_W'(k);
        sel_valid = 1'b1;
      end
    end
  end

  // Lowest free entry, a leaving one counts only when captured
  always_comb begin
    ins_idx   = '0;
    ins_valid = 1'b0;
    for (int k = BUF_LEN - 1; k >= 0; k--) begin
      if (!valid_q[k] || (capture && (sel_idx == IDX_W'(k)))) begin
        ins_idx   = IDX_W'(k);
        ins_valid = 1'b1;
      end
    end
  end

  assign req_rdy_o      = init_done_q && !flush_i && ins_valid;
  assign accept         = req_i.valid && req_rdy_o;
  assign lookup_en_o    = accept;
  assign lookup_paddr_o = req_i.paddr;

  assign sel_req    = req_q[sel_idx];
  assign rd_paddr_o = sel_req.paddr;
  // Line write lands on the capture edge
  assign wr_en_o    = capture && (sel_req.req_type == DWriteLine);
  assign wr_paddr_o = sel_req.paddr;
  assign wr_line_o  = sel_req.line;

  always_comb begin
    ans_d       = '0;
    ans_d.valid = 1'b1;
    ans_d.paddr = sel_req.paddr;
    case (sel_req.req_type)
      IReadLine: begin
        ans_d.ans_type = ILineRead;
        ans_d.line     = rd_line_i;
      end
      DReadLine: begin
        ans_d.ans_type = DLineRead;
        ans_d.line     = rd_line_i;
      end
      DWriteLine: begin
        // Miss wakes the write-back buffer entry
        ans_d.ans_type = miss_q[sel_idx] ? DWbbWakeUp : DLineWritten;
        ans_d.wbb_tag  = sel_req.wbb_tag;
      end
      default: begin
        ans_d.ans_type = PTWLoadAns;
        ans_d.data     = rd_data_i;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= '0;
      init_done_q <= 1'b0;
      ans_q       <= '0;
      for (int k = 0; k < BUF_LEN; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      init_done_q <= 1'b1;
      for (int k = 0; k < BUF_LEN; k++) begin
        if (flush_i) begin
          valid_q[k] <= 1'b0;
        end else if (accept && (ins_idx == IDX_W'(k))) begin
          valid_q[k] <= 1'b1;
          cnt_q[k]   <= hit_i ? CNT_W'(HIT_DELAY) : CNT_W'(MISS_DELAY);
        end else if (capture && (sel_idx == IDX_W'(k))) begin
          valid_q[k] <= 1'b0;
        end else if (valid_q[k] && (cnt_q[k] != '0) && !ans_block) begin
          // Countdown frozen under back-pressure
          cnt_q[k] <= cnt_q[k] - 1'b1;
        end
      end
      if (capture) begin
        ans_q <= ans_d;
      end else if (ans_rdy_i) begin
        ans_q.valid <= 1'b0;
      end
    end
  end

  // Request payload and miss flag of a new entry
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q[ins_idx]  <= req_i;
      miss_q[ins_idx] <= !hit_i;
    end
  end

  assign ans_o = ans_q;

endmodule

// File: rtl/l2_pkg.sv
package l2_pkg;

  // Address and doubleword width
  localparam int unsigned XLEN         = 64;
  // Cache line of 64 bytes
  localparam int unsigned LINE_BITS    = 512;
  localparam int unsigned DW_PER_LINE  = LINE_BITS / XLEN;
  // Doubleword select inside a line
  localparam int unsigned OFF_BITS     = 3;
  // Byte offset inside a doubleword, always zero in a request
  localparam int unsigned BYTE_BITS    = 3;
  localparam int unsigned IDX_BITS     = 6;
  localparam int unsigned TAG_BITS     = XLEN - IDX_BITS - OFF_BITS - BYTE_BITS;
  // Tag table depth
  localparam int unsigned SETS         = 2 ** IDX_BITS;
  // Low tag bits that take part in line store addressing
  localparam int unsigned LS_TAG_BITS  = 2;
  localparam int unsigned WBB_TAG_BITS = 4;

  // Physical address without the zero byte offset
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic [IDX_BITS-1:0] idx;
    logic [OFF_BITS-1:0] line_off;
  } l2_paddr_t;

  typedef enum logic [1:0] {
    IReadLine,
    DReadLine,
    DWriteLine,
    PTWLoad
  } l2_req_type_e;

  // Walker answer label differs from the request label, both share one scope
  typedef enum logic [2:0] {
    ILineRead,
    DLineRead,
    DLineWritten,
    DWbbWakeUp,
    PTWLoadAns
  } l2_ans_type_e;

  // Request channel from a client or from the arbiter
  typedef struct packed {
    logic                    valid;
    l2_req_type_e            req_type;
    l2_paddr_t               paddr;
    logic [LINE_BITS-1:0]    line;
    logic [WBB_TAG_BITS-1:0] wbb_tag;
  } l2_req_t;

  // Answer channel towards the clients
  typedef struct packed {
    logic                    valid;
    l2_ans_type_e            ans_type;
    l2_paddr_t               paddr;
    logic [LINE_BITS-1:0]    line;
    logic [XLEN-1:0]         data;
    logic [WBB_TAG_BITS-1:0] wbb_tag;
  } l2_ans_t;

endpackage

// File: rtl/l2_req_arbiter.sv
`timescale 1ns/1ps

module l2_req_arbiter import l2_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  l2_req_t icache_req_i,
  input  l2_req_t dcache_req_i,
  input  l2_req_t ptw_req_i,
  output logic    icache_rdy_o,
  output logic    dcache_rdy_o,
  output logic    ptw_rdy_o,
  output l2_req_t req_o,
  input  logic    req_rdy_i
);

  l2_req_t    req_vec [3];
  logic [2:0] valid_vec;
  logic [1:0] last_q;
  logic [1:0] lock_idx_q;
  logic       lock_q;
  logic [1:0] gnt_idx;
  logic [1:0] cand;
  logic       gnt_valid;

  // Client order: I-cache, D-cache, walker
  assign req_vec[0] = icache_req_i;
  assign req_vec[1] = dcache_req_i;
  assign req_vec[2] = ptw_req_i;
  assign valid_vec  = {ptw_req_i.valid, dcache_req_i.valid, icache_req_i.valid};

  always_comb begin
    gnt_idx   = last_q;
    gnt_valid = 1'b0;
    cand      = '0;
    if (lock_q) begin
      // Stalled offer keeps its client
      gnt_idx   = lock_idx_q;
      gnt_valid = valid_vec[lock_idx_q];
    end else begin
      // Scan from farthest to nearest, so the client right after last wins
      for (int n = 3; n >= 1; n--) begin
        cand = 2'((int'(last_q) + n) % 3);
        if (valid_vec[cand]) begin
          gnt_idx   = cand;
          gnt_valid = 1'b1;
        end
      end
    end
  end

  assign req_o = gnt_valid ? req_vec[gnt_idx] : '0;

  // Ready only to the granted client
  assign icache_rdy_o = gnt_valid && (gnt_idx == 2'd0) && req_rdy_i;
  assign dcache_rdy_o = gnt_valid && (gnt_idx == 2'd1) && req_rdy_i;
  assign ptw_rdy_o    = gnt_valid && (gnt_idx == 2'd2) && req_rdy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Walker as last grant, I-cache goes first
      last_q     <= 2'd2;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (gnt_valid && req_rdy_i) begin
      last_q <= gnt_idx;
      lock_q <= 1'b0;
    end else if (gnt_valid) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end else begin
      lock_q <= 1'b0;
    end
  end

endmodule

// File: rtl/l2_sys.sv
`timescale 1ns/1ps

module l2_sys import l2_pkg::*; #(
  parameter int unsigned BUF_LEN    = 3,
  parameter int unsigned HIT_DELAY  = 2,
  parameter int unsigned MISS_DELAY = 7
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    flush_i,
  input  l2_req_t icache_req_i,
  output logic    icache_rdy_o,
  input  l2_req_t dcache_req_i,
  output logic    dcache_rdy_o,
  input  l2_req_t ptw_req_i,
  output logic    ptw_rdy_o,
  output l2_ans_t icache_ans_o,
  input  logic    icache_ans_rdy_i,
  output l2_ans_t dcache_ans_o,
  input  logic    dcache_ans_rdy_i,
  output l2_ans_t ptw_ans_o,
  input  logic    ptw_ans_rdy_i
);

  l2_req_t              arb_req;
  logic                 arb_req_rdy;
  logic                 lookup_en;
  l2_paddr_t            lookup_paddr;
  logic                 hit;
  l2_paddr_t            rd_paddr;
  logic [LINE_BITS-1:0] rd_line;
  logic [XLEN-1:0]      rd_data;
  logic                 wr_en;
  l2_paddr_t            wr_paddr;
  logic [LINE_BITS-1:0] wr_line;
  l2_ans_t              ans;
  logic                 ans_rdy;

  // Three clients merged onto one channel
  l2_req_arbiter u_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .icache_req_i (icache_req_i),
    .dcache_req_i (dcache_req_i),
    .ptw_req_i    (ptw_req_i),
    .icache_rdy_o (icache_rdy_o),
    .dcache_rdy_o (dcache_rdy_o),
    .ptw_rdy_o    (ptw_rdy_o),
    .req_o        (arb_req),
    .req_rdy_i    (arb_req_rdy)
  );

  l2_tag_table u_tag_table (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lookup_en_i    (lookup_en),
    .lookup_paddr_i (lookup_paddr),
    .hit_o          (hit)
  );

  l2_pending_buffer #(
    .BUF_LEN    (BUF_LEN),
    .HIT_DELAY  (HIT_DELAY),
    .MISS_DELAY (MISS_DELAY)
  ) u_pending_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .req_i          (arb_req),
    .req_rdy_o      (arb_req_rdy),
    .lookup_en_o    (lookup_en),
    .lookup_paddr_o (lookup_paddr),
    .hit_i          (hit),
    .rd_paddr_o     (rd_paddr),
    .rd_line_i      (rd_line),
    .rd_data_i      (rd_data),
    .wr_en_o        (wr_en),
    .wr_paddr_o     (wr_paddr),
    .wr_line_o      (wr_line),
    .ans_o          (ans),
    .ans_rdy_i      (ans_rdy)
  );

  l2_line_store u_line_store (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_paddr_i (rd_paddr),
    .rd_line_o  (rd_line),
    .rd_data_o  (rd_data),
    .wr_en_i    (wr_en),
    .wr_paddr_i (wr_paddr),
    .wr_line_i  (wr_line)
  );

  // Answer back to the client that asked
  l2_ans_router u_router (
    .ans_i        (ans),
    .ans_rdy_o    (ans_rdy),
    .icache_ans_o (icache_ans_o),
    .dcache_ans_o (dcache_ans_o),
    .ptw_ans_o    (ptw_ans_o),
    .icache_rdy_i (icache_ans_rdy_i),
    .dcache_rdy_i (dcache_ans_rdy_i),
    .ptw_rdy_i    (ptw_ans_rdy_i)
  );

endmodule

// File: rtl/l2_tag_table.sv
`timescale 1ns/1ps

module l2_tag_table import l2_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      lookup_en_i,
  input  l2_paddr_t lookup_paddr_i,
  output logic      hit_o
);

  logic [SETS-1:0]     valid_q;
  logic [TAG_BITS-1:0] tag_q [SETS];
  logic [IDX_BITS-1:0] idx;
  logic                match;

  assign idx   = lookup_paddr_i.idx;
  // Stored tag at this set equals the request tag
  assign match = valid_q[idx] && (tag_q[idx] == lookup_paddr_i.tag);
  assign hit_o = lookup_en_i && match;

  // Valid bits start cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (lookup_en_i && !match) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // Install the tag on a missing lookup, reads and writes alike
  always_ff @(posedge clk_i) begin
    if (lookup_en_i && !match) begin
      tag_q[idx] <= lookup_paddr_i.tag;
    end
  end

endmodule

// File: test/l2_sys_chk.sv
`timescale 1ns/1ps

module l2_sys_chk import l2_pkg::*; #(
  parameter int unsigned BUF_LEN = 3
) (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               flush_i,
  input l2_req_t            req_i,
  input logic               req_rdy_i,
  input logic               cap_i,
  input l2_ans_t            ans_i,
  input logic               ans_rdy_i,
  input logic [BUF_LEN-1:0] pend_i
);

  // Requests taken and not yet moved to the answer register
  int occ_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= 0;
    end else if (flush_i) begin
      occ_q <= 0;
    end else begin
      occ_q <= occ_q + int'(req_i.valid && req_rdy_i) - int'(cap_i);
    end
  end

  // Offered request holds until taken
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i.valid && !req_rdy_i) |=> $stable(req_i))
    else $error("request changed while offered and not taken");

  // Answer holds until taken
  ans_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ans_i.valid && !ans_rdy_i) |=> $stable(ans_i))
    else $error("answer changed while offered and not taken");

  // Quiet outputs and empty buffer in reset
  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> (!req_rdy_i && !ans_i.valid && (pend_i == '0)))
    else $error("valid or ready high during reset");

  // Never more pending requests than the buffer holds
  pend_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (occ_q >= 0) && (occ_q <= int'(BUF_LEN)))
    else $error("pending count above buffer length");

  // Entry valid bits agree with accepted minus captured requests
  pend_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    occ_q == $countones(pend_i))
    else $error("pending entries differ from accepted minus captured");

endmodule

// File: test/tb_l2_sys.sv
`timescale 1ns/1ps

module tb_l2_sys import l2_pkg::*; ();

  localparam int unsigned BUF_LEN    = 3;
  localparam int unsigned HIT_DELAY  = 2;
  localparam int unsigned MISS_DELAY = 7;
  localparam int unsigned TIMEOUT    = 200;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  l2_req_t     req_drv [3];
  logic        req_rdy [3];
  l2_ans_t     ans [3];
  logic        ans_rdy [3];
  logic        hold;
  logic        rand_bp;
  int unsigned cyc;
  int unsigned gnt_cnt;
  int unsigned last_acc;
  int unsigned last_ans;
  int unsigned n_ans;

  // Reference tag table and line image keyed by line store address
  logic [SETS-1:0]      ref_valid;
  logic [TAG_BITS-1:0]  ref_tag [SETS];
  logic [LINE_BITS-1:0] img [int];
  // Outstanding answers and the client each belongs to
  l2_ans_t              exp_ans [$];
  int                   exp_cli [$];

  l2_sys #(
    .BUF_LEN    (BUF_LEN),
    .HIT_DELAY  (HIT_DELAY),
    .MISS_DELAY (MISS_DELAY)
  ) l2_sys_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .icache_req_i     (req_drv[0]),
    .icache_rdy_o     (req_rdy[0]),
    .dcache_req_i     (req_drv[1]),
    .dcache_rdy_o     (req_rdy[1]),
    .ptw_req_i        (req_drv[2]),
    .ptw_rdy_o        (req_rdy[2]),
    .icache_ans_o     (ans[0]),
    .icache_ans_rdy_i (ans_rdy[0]),
    .dcache_ans_o     (ans[1]),
    .dcache_ans_rdy_i (ans_rdy[1]),
    .ptw_ans_o        (ans[2]),
    .ptw_ans_rdy_i    (ans_rdy[2])
  );

  bind l2_pending_buffer l2_sys_chk #(.BUF_LEN(BUF_LEN)) u_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i), .req_i(req_i),
    .req_rdy_i(req_rdy_o), .cap_i(capture), .ans_i(ans_o), .ans_rdy_i(ans_rdy_i),
    .pend_i(valid_q)
  );
  bind l2_req_arbiter l2_sys_chk #(.BUF_LEN(1)) u_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(1'b0), .req_i(req_o), .req_rdy_i(req_rdy_i),
    .cap_i(req_o.valid && req_rdy_i), .ans_i('0), .ans_rdy_i(1'b1), .pend_i(1'b0)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_timeout(input string msg);
    $display("timeout at %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "stopped on timeout");
  endtask

  // Doubleword k of a reset line is the line address plus k
  function automatic logic [LINE_BITS-1:0] reset_line(l2_paddr_t p);
    logic [LINE_BITS-1:0] l;
    logic [XLEN-1:0]      base;
    base = {p.tag, p.idx, 6'b0};
    for (int k = 0; k < DW_PER_LINE; k++) begin
      l[k*XLEN +: XLEN] = base + XLEN'(k);
    end
    return l;
  endfunction

  function automatic int store_key(l2_paddr_t p);
    return int'({p.tag[1:0], p.idx});
  endfunction

  function automatic logic [LINE_BITS-1:0] ref_line(l2_paddr_t p);
    if (img.exists(store_key(p))) begin
      return img[store_key(p)];
    end
    return reset_line(p);
  endfunction

  // Direct-mapped lookup where a miss installs the tag
  function automatic logic ref_lookup(l2_paddr_t p);
    logic h;
    h = ref_valid[p.idx] && (ref_tag[p.idx] == p.tag);
    if (!h) begin
      ref_valid[p.idx] = 1'b1;
      ref_tag[p.idx]   = p.tag;
    end
    return h;
  endfunction

  function automatic l2_ans_t expect_ans(l2_req_t r, logic hit);
    l2_ans_t              a;
    logic [LINE_BITS-1:0] l;
    a       = '0;
    a.valid = 1'b1;
    a.paddr = r.paddr;
    l       = ref_line(r.paddr);
    case (r.req_type)
      IReadLine: begin
        a.ans_type = ILineRead;
        a.line     = l;
      end
      DReadLine: begin
        a.ans_type = DLineRead;
        a.line     = l;
      end
      DWriteLine: begin
        a.ans_type = hit ? DLineWritten : DWbbWakeUp;
        a.wbb_tag  = r.wbb_tag;
      end
      default: begin
        a.ans_type = PTWLoadAns;
        a.data     = l[r.paddr.line_off*XLEN +: XLEN];
      end
    endcase
    return a;
  endfunction

  function automatic l2_req_t make_req(l2_req_type_e ty, int unsigned tag, int unsigned idx,
                                       int unsigned off, logic [LINE_BITS-1:0] line,
                                       logic [WBB_TAG_BITS-1:0] wbb);
    l2_req_t r;
    r                = '0;
    r.valid          = 1'b1;
    r.req_type       = ty;
    r.paddr.tag      = TAG_BITS'(tag);
    r.paddr.idx      = IDX_BITS'(idx);
    r.paddr.line_off = OFF_BITS'(off);
    r.line           = line;
    r.wbb_tag        = wbb;
    return r;
  endfunction

  // Offer on a falling edge, hold until taken, then record the expectation
  task automatic send(input int c, input l2_req_t r, input logic keep);
    int unsigned t;
    int unsigned g0;
    logic        hit;
    t = 0;
    @(negedge clk_i);
    req_drv[c] = r;
    g0         = gnt_cnt;
    #1;
    while (!req_rdy[c]) begin
      t++;
      if (t > TIMEOUT) report_timeout("request was never accepted");
      @(negedge clk_i);
      #1;
    end
    assert (gnt_cnt - g0 <= 2)
      else report_error($sformatf("client %0d waited %0d grants", c, gnt_cnt - g0));
    gnt_cnt++;
    last_acc = cyc + 1;
    hit      = ref_lookup(r.paddr);
    if (keep) begin
      exp_ans.push_back(expect_ans(r, hit));
      exp_cli.push_back(c);
    end
    if (r.req_type == DWriteLine) img[store_key(r.paddr)] = r.line;
    @(negedge clk_i);
    req_drv[c] = '0;
  endtask

  task automatic wait_drain();
    int unsigned t;
    t = 0;
    while (exp_ans.size() != 0) begin
      @(negedge clk_i);
      t++;
      if (t > 4 * TIMEOUT) report_timeout("outstanding answers never arrived");
    end
  endtask

  task automatic random_stream(input int c, input int n);
    l2_req_t      r;
    l2_req_type_e ty;
    int unsigned  gap;
    case (c)
      0:       ty = IReadLine;
      1:       ty = DReadLine;
      default: ty = PTWLoad;
    endcase
    for (int i = 0; i < n; i++) begin
      gap = $urandom_range(0, 3);
      repeat (gap) @(negedge clk_i);
      r = make_req(ty, $urandom_range(0, 3), $urandom_range(0, 15),
                   $urandom_range(0, 7), '0, '0);
      send(c, r, 1'b1);
    end
  endtask

  // Drives answer ready and matches every delivered answer
  initial begin : compare_answers
    int idx;
    forever begin
      @(negedge clk_i);
      for (int c = 0; c < 3; c++) begin
        ans_rdy[c] = !hold && (!rand_bp || ($urandom_range(0, 1) == 1));
      end
      #1;
      for (int c = 0; c < 3; c++) begin
        if (ans[c].valid && ans_rdy[c]) begin
          idx = -1;
          for (int i = 0; i < exp_ans.size(); i++) begin
            if (idx < 0 && exp_cli[i] == c && exp_ans[i] == ans[c]) idx = i;
          end
          assert (idx >= 0)
            else report_error($sformatf("client %0d got unexpected answer type %0d addr %h",
                                        c, ans[c].ans_type, ans[c].paddr));
          exp_ans.delete(idx);
          exp_cli.delete(idx);
          last_ans = cyc;
          n_ans++;
        end
      end
    end
  end

  initial begin : main
    logic [LINE_BITS-1:0] wline;
    int unsigned          n0;
    void'($urandom(76));
    rst_ni    = 1'b0;
    flush_i   = 1'b0;
    hold      = 1'b0;
    rand_bp   = 1'b0;
    cyc       = 0;
    gnt_cnt   = 0;
    n_ans     = 0;
    last_acc  = 0;
    last_ans  = 0;
    ref_valid = '0;
    for (int c = 0; c < 3; c++) begin
      req_drv[c] = '0;
      ans_rdy[c] = 1'b0;
    end
    for (int k = 0; k < DW_PER_LINE; k++) begin
      wline[k*XLEN +: XLEN] = 64'hC0DE_0000_0000_0000 + XLEN'(k);
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset pattern reads on every client
    send(0, make_req(IReadLine, 0, 1, 0, '0, '0), 1'b1);
    send(1, make_req(DReadLine, 1, 2, 0, '0, '0), 1'b1);
    send(2, make_req(PTWLoad, 2, 3, 5, '0, '0), 1'b1);
    wait_drain();

    // Miss then hit timing on one line
    send(1, make_req(DReadLine, 3, 9, 0, '0, '0), 1'b1);
    wait_drain();
    assert (last_ans - last_acc == MISS_DELAY + 1)
      else report_error($sformatf("miss latency %0d", last_ans - last_acc));
    send(1, make_req(DReadLine, 3, 9, 2, '0, '0), 1'b1);
    wait_drain();
    assert (last_ans - last_acc == HIT_DELAY + 1)
      else report_error($sformatf("hit latency %0d", last_ans - last_acc));

    // Write miss wakes the buffer entry and a write hit reports written
    send(1, make_req(DWriteLine, 0, 20, 0, wline, 4'h5), 1'b1);
    wait_drain();
    send(1, make_req(DWriteLine, 0, 20, 0, wline, 4'hA), 1'b1);
    wait_drain();
    assert (last_ans - last_acc == HIT_DELAY + 1)
      else report_error($sformatf("write hit latency %0d", last_ans - last_acc));

    // Read back the written line
    send(1, make_req(DReadLine, 0, 20, 0, '0, '0), 1'b1);
    send(2, make_req(PTWLoad, 0, 20, 3, '0, '0), 1'b1);
    wait_drain();

    // All clients at once
    fork
      random_stream(0, 12);
      random_stream(1, 12);
      random_stream(2, 12);
    join
    wait_drain();

    // Same with random answer back-pressure
    rand_bp = 1'b1;
    fork
      random_stream(0, 12);
      random_stream(1, 12);
      random_stream(2, 12);
    join
    wait_drain();
    rand_bp = 1'b0;

    // Full buffer with answers blocked
    hold = 1'b1;
    for (int i = 0; i <= BUF_LEN; i++) begin
      send(1, make_req(DReadLine, 2, 40 + i, 0, '0, '0), 1'b1);
    end
    repeat (MISS_DELAY + 4) @(negedge clk_i);
    #1;
    assert (l2_sys_inst.u_pending_buffer.req_rdy_o == 1'b0)
      else report_error("request ready high with a full buffer");
    hold = 1'b0;
    wait_drain();

    // Flush drops an accepted request
    send(1, make_req(DReadLine, 1, 50, 0, '0, '0), 1'b0);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    n0 = n_ans;
    repeat (MISS_DELAY + 6) @(negedge clk_i);
    assert (n_ans == n0)
      else report_error("answer delivered for a flushed request");
    send(0, make_req(IReadLine, 1, 51, 0, '0, '0), 1'b1);
    wait_drain();

    if (exp_ans.size() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
